//--- logic/byte_rx_sync.sv
// four-phase slave on the host byte input
// hands the parser one beat per request phase
module byte_rx_sync (
    input  logic                 rx_flag,
    input  logic                 transFinish,
    input  logic                 in_req,
    input  logic [7:0]           in_data,
    output logic                 in_ack,
    input  logic                 rx_ready,
    output ctrl_pkg::byte_beat_t rx_beat
);

    // two-flop sync of the host request
    logic req_meta;
    logic req_sync;
    // byte taken on this clock
    logic take;

    // new phase only, and only while the parser can take it
    assign take = req_sync && !in_ack && rx_ready;

    always_ff @(posedge rx_flag or posedge transFinish) begin
        if (transFinish) begin
            req_meta <= 1'b0;
            req_sync <= 1'b0;
            in_ack   <= 1'b0;
            rx_beat  <= '0;
        end else begin
            req_meta <= in_req;
            req_sync <= req_meta;
            // beat is a single clock pulse
            rx_beat.valid <= take;
            if (take) begin
                // host holds data stable while req is high
                rx_beat.data <= in_data;
                in_ack       <= 1'b1;
            end else if (!req_sync) begin
                // release only once the request is gone
                in_ack <= 1'b0;
            end
        end
    end

endmodule

//--- logic/ctrl_defs.svh
// constants for the byte-stream command controller
// include where frame bytes, memory sizes or flash timing are needed
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

////////////////////
// frame bytes
////////////////////
// start of every host frame
`define CTRL_HEAD_BYTE 8'haa
// answer to a finished write
`define CTRL_ACK_BYTE 8'h55
// answer to an opcode we do not know
`define CTRL_NAK_BYTE 8'hee

////////////////////
// memories
////////////////////
// bytes of on-chip ram, address taken modulo this
`define CTRL_RAM_DEPTH 64
// bytes in the emulated flash page
`define CTRL_FLASH_DEPTH 32
// clocks the flash stays busy per programmed byte
`define CTRL_FLASH_BUSY 4

`endif

//--- logic/ctrl_pkg.sv
// types shared by the controller blocks
// parser states, opcodes and the structs on the internal links
package ctrl_pkg;

    // parser state, also shown at the top as status
    typedef enum logic [7:0] {
        wait_head    = 8'h01,
        wait_length  = 8'h02,
        wait_command = 8'h03,
        wait_address = 8'h04,
        ram_write    = 8'h05,
        ram_read     = 8'h06,
        flash_write  = 8'h07,
        flash_read   = 8'h08,
        send_reply   = 8'h09
    } parser_state_e;

    // opcodes as the host sends them
    typedef enum logic [7:0] {
        cmd_read_ram    = 8'h01,
        cmd_write_ram   = 8'h02,
        cmd_write_flash = 8'h04,
        cmd_read_flash  = 8'h08
    } command_e;

    // which byte the reply path takes
    typedef enum logic [1:0] {
        sel_engine = 2'd0,
        sel_ack    = 2'd1,
        sel_nak    = 2'd2
    } reply_sel_e;

    // one byte plus its strobe
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byte_beat_t;

    // engine access, strobes last one clock
    typedef struct packed {
        logic       wr;
        logic       rd;
        logic [7:0] addr;
        logic [7:0] data;
    } mem_req_t;

    // parser reply, data only meaningful for ack and nak
    typedef struct packed {
        reply_sel_e sel;
        logic [7:0] data;
    } reply_t;

endpackage

//--- logic/ctrl_top.sv
// command controller top level
// host bytes in and reply bytes out, both four-phase
module ctrl_top (
    input  logic                    rx_flag,
    input  logic                    transFinish,
    input  logic                    in_req,
    input  logic [7:0]              in_data,
    output logic                    in_ack,
    output logic                    out_req,
    output logic [7:0]              out_data,
    input  logic                    out_ack,
    output ctrl_pkg::parser_state_e status
);
    import ctrl_pkg::*;

    // receiver to parser
    byte_beat_t rx_beat;
    logic       rx_ready;
    // parser to engines
    mem_req_t   ram_req;
    mem_req_t   flash_req;
    logic       flash_busy;
    // into the reply path
    byte_beat_t ram_beat;
    byte_beat_t flash_beat;
    reply_t     reply;
    logic       tx_ready;

    byte_rx_sync i_byte_rx_sync (
        .rx_flag     (rx_flag),
        .transFinish (transFinish),
        .in_req      (in_req),
        .in_data     (in_data),
        .in_ack      (in_ack),
        .rx_ready    (rx_ready),
        .rx_beat     (rx_beat)
    );

    frame_parser i_frame_parser (
        .rx_flag     (rx_flag),
        .transFinish (transFinish),
        .rx_beat     (rx_beat),
        .rx_ready    (rx_ready),
        .tx_ready    (tx_ready),
        .ram_req     (ram_req),
        .flash_req   (flash_req),
        .flash_busy  (flash_busy),
        .reply       (reply),
        .status      (status)
    );

    ram_engine i_ram_engine (
        .rx_flag (rx_flag),
        .ram_req (ram_req),
        .rd_beat (ram_beat)
    );

    flash_engine i_flash_engine (
        .rx_flag     (rx_flag),
        .transFinish (transFinish),
        .flash_req   (flash_req),
        .flash_busy  (flash_busy),
        .rd_beat     (flash_beat)
    );

    resp_tx i_resp_tx (
        .rx_flag     (rx_flag),
        .transFinish (transFinish),
        .ram_beat    (ram_beat),
        .flash_beat  (flash_beat),
        .reply       (reply),
        .tx_ready    (tx_ready),
        .out_req     (out_req),
        .out_data    (out_data),
        .out_ack     (out_ack)
    );

endmodule

//--- logic/flash_engine.sv
// emulated flash page, all ones after reset
// programming can only clear bits and keeps the page busy a while
`include "ctrl_defs.svh"

module flash_engine (
    input  logic                 rx_flag,
    input  logic                 transFinish,
    input  ctrl_pkg::mem_req_t   flash_req,
    output logic                 flash_busy,
    output ctrl_pkg::byte_beat_t rd_beat
);

    localparam int addr_w = $clog2(`CTRL_FLASH_DEPTH);
    localparam int cnt_w  = $clog2(`CTRL_FLASH_BUSY + 1);

    logic [7:0]        page [`CTRL_FLASH_DEPTH];
    logic [addr_w-1:0] idx;
    // busy time left for the byte being programmed
    logic [cnt_w-1:0]  busy_cnt;

    assign idx        = flash_req.addr[addr_w-1:0];
    assign flash_busy = (busy_cnt != '0);

    always_ff @(posedge rx_flag or posedge transFinish) begin
        if (transFinish) begin
            // erased page
            for (int i = 0; i < `CTRL_FLASH_DEPTH; i++) begin
                page[i] <= 8'hff;
            end
            busy_cnt <= '0;
            rd_beat  <= '0;
        end else begin
            if (flash_req.wr) begin
                // a one can never come back without erase
                page[idx] <= page[idx] & flash_req.data;
                busy_cnt  <= cnt_w'(`CTRL_FLASH_BUSY);
            end else if (flash_busy) begin
                busy_cnt <= busy_cnt - 1'b1;
            end
            // read timing same as the ram
            rd_beat.valid <= flash_req.rd;
            if (flash_req.rd) begin
                rd_beat.data <= page[idx];
            end
        end
    end

endmodule

//--- logic/frame_parser.sv
// frame state machine: head, length, command, address, then transfer
// drives the engines and asks the reply path for ack or nak
`include "ctrl_defs.svh"

module frame_parser (
    input  logic                    rx_flag,
    input  logic                    transFinish,
    input  ctrl_pkg::byte_beat_t    rx_beat,
    output logic                    rx_ready,
    input  logic                    tx_ready,
    output ctrl_pkg::mem_req_t      ram_req,
    output ctrl_pkg::mem_req_t      flash_req,
    input  logic                    flash_busy,
    output ctrl_pkg::reply_t        reply,
    output ctrl_pkg::parser_state_e status
);
    import ctrl_pkg::*;

    parser_state_e state;
    command_e      cmd;
    reply_sel_e    pend_sel;
    // frame length and progress
    logic [7:0]    length;
    logic [7:0]    count;
    logic [7:0]    addr;
    // read strobe out, byte not yet taken by the reply path
    logic          rd_wait;
    logic          last_byte;
    // request templates for the transfer states
    mem_req_t      wr_req;
    mem_req_t      rd_req;

    assign status    = state;
    assign last_byte = (count == length - 8'd1);
    assign wr_req    = '{wr: 1'b1, rd: 1'b0, addr: addr, data: rx_beat.data};
    assign rd_req    = '{wr: 1'b0, rd: 1'b1, addr: addr, data: 8'h00};

    // host bytes welcome in the header and write states
    always_comb begin
        case (state)
            wait_head, wait_length, wait_command, wait_address, ram_write:
                rx_ready = 1'b1;
            // hold off until the flash has finished the last byte
            flash_write:
                rx_ready = !(rx_beat.valid || flash_req.wr || flash_busy);
            default:
                rx_ready = 1'b0;
        endcase
    end

    always_ff @(posedge rx_flag or posedge transFinish) begin
        if (transFinish) begin
            state     <= wait_head;
            cmd       <= cmd_read_ram;
            pend_sel  <= sel_ack;
            length    <= '0;
            count     <= '0;
            addr      <= '0;
            rd_wait   <= 1'b0;
            ram_req   <= '0;
            flash_req <= '0;
            reply     <= '{sel: sel_engine, data: 8'h00};
        end else begin
            // strobes and replies are single pulses
            ram_req.wr   <= 1'b0;
            ram_req.rd   <= 1'b0;
            flash_req.wr <= 1'b0;
            flash_req.rd <= 1'b0;
            reply        <= '{sel: sel_engine, data: 8'h00};
            // reply path busy again, so the byte was taken
            if (!tx_ready) begin
                rd_wait <= 1'b0;
            end

            case (state)
                ////////////////////
                // header states
                ////////////////////
                wait_head:
                    // anything but the head byte is dropped
                    if (rx_beat.valid && rx_beat.data == `CTRL_HEAD_BYTE) begin
                        state <= wait_length;
                    end
                wait_length:
                    if (rx_beat.valid) begin
                        length <= rx_beat.data;
                        state  <= wait_command;
                    end
                wait_command:
                    if (rx_beat.valid) begin
                        case (rx_beat.data)
                            cmd_read_ram, cmd_write_ram, cmd_write_flash, cmd_read_flash: begin
                                cmd   <= command_e'(rx_beat.data);
                                state <= wait_address;
                            end
                            default: begin
                                // refuse, then back to head search
                                pend_sel <= sel_nak;
                                state    <= send_reply;
                            end
                        endcase
                    end
                wait_address:
                    if (rx_beat.valid) begin
                        addr  <= rx_beat.data;
                        count <= '0;
                        if (length == 8'd0) begin
                            // empty write still acks, empty read says nothing
                            if (cmd == cmd_write_ram || cmd == cmd_write_flash) begin
                                pend_sel <= sel_ack;
                                state    <= send_reply;
                            end else begin
                                state <= wait_head;
                            end
                        end else begin
                            case (cmd)
                                cmd_write_ram:   state <= ram_write;
                                cmd_read_ram:    state <= ram_read;
                                cmd_write_flash: state <= flash_write;
                                default:         state <= flash_read;
                            endcase
                        end
                    end
                ////////////////////
                // transfer states
                ////////////////////
                ram_write, flash_write:
                    if (rx_beat.valid) begin
                        if (state == ram_write) begin
                            ram_req <= wr_req;
                        end else begin
                            flash_req <= wr_req;
                        end
                        addr  <= addr + 8'd1;
                        count <= count + 8'd1;
                        if (last_byte) begin
                            pend_sel <= sel_ack;
                            state    <= send_reply;
                        end
                    end
                ram_read, flash_read:
                    // one strobe per free slot in the reply path
                    if (tx_ready && !rd_wait) begin
                        if (state == ram_read) begin
                            ram_req <= rd_req;
                        end else begin
                            flash_req <= rd_req;
                        end
                        rd_wait <= 1'b1;
                        addr    <= addr + 8'd1;
                        count   <= count + 8'd1;
                        if (last_byte) begin
                            state <= wait_head;
                        end
                    end
                send_reply:
                    // wait for reads in flight and flash programming to finish
                    if (tx_ready && !rd_wait && !flash_busy && !flash_req.wr) begin
                        reply.sel  <= pend_sel;
                        reply.data <= (pend_sel == sel_nak) ? `CTRL_NAK_BYTE : `CTRL_ACK_BYTE;
                        state      <= wait_head;
                    end
                default:
                    state <= wait_head;
            endcase
        end
    end

endmodule

//--- logic/ram_engine.sv
// on-chip byte ram behind the parser
// write on the strobe clock, read byte valid one clock after its strobe
`include "ctrl_defs.svh"

module ram_engine (
    input  logic                 rx_flag,
    input  ctrl_pkg::mem_req_t   ram_req,
    output ctrl_pkg::byte_beat_t rd_beat
);

    localparam int addr_w = $clog2(`CTRL_RAM_DEPTH);

    logic [7:0]        mem [`CTRL_RAM_DEPTH];
    // upper address bits dropped, so addresses wrap on the depth
    logic [addr_w-1:0] idx;

    assign idx = ram_req.addr[addr_w-1:0];

    always_ff @(posedge rx_flag) begin
        if (ram_req.wr) begin
            mem[idx] <= ram_req.data;
        end
        // registered read port
        rd_beat.valid <= ram_req.rd;
        if (ram_req.rd) begin
            rd_beat.data <= mem[idx];
        end
    end

endmodule

//--- logic/resp_tx.sv
// reply path: picks the one valid byte source and
// sends it to the host as four-phase master on out_req / out_ack
module resp_tx (
    input  logic                 rx_flag,
    input  logic                 transFinish,
    input  ctrl_pkg::byte_beat_t ram_beat,
    input  ctrl_pkg::byte_beat_t flash_beat,
    input  ctrl_pkg::reply_t     reply,
    output logic                 tx_ready,
    output logic                 out_req,
    output logic [7:0]           out_data,
    input  logic                 out_ack
);
    import ctrl_pkg::*;

    typedef enum logic [1:0] {
        tx_idle,
        tx_send,
        tx_release
    } tx_state_e;

    tx_state_e  state;
    // host ack through two flops
    logic       ack_meta;
    logic       ack_sync;
    logic       src_valid;
    logic [7:0] src_byte;

    // parser reply wins, else whichever engine has data
    always_comb begin
        src_valid = 1'b1;
        src_byte  = reply.data;
        if (reply.sel == sel_engine) begin
            src_valid = ram_beat.valid || flash_beat.valid;
            src_byte  = ram_beat.valid ? ram_beat.data : flash_beat.data;
        end
    end

    assign tx_ready = (state == tx_idle);

    always_ff @(posedge rx_flag or posedge transFinish) begin
        if (transFinish) begin
            state    <= tx_idle;
            ack_meta <= 1'b0;
            ack_sync <= 1'b0;
            out_req  <= 1'b0;
            out_data <= 8'h00;
        end else begin
            ack_meta <= out_ack;
            ack_sync <= ack_meta;
            case (state)
                tx_idle:
                    if (src_valid) begin
                        out_data <= src_byte;
                        out_req  <= 1'b1;
                        state    <= tx_send;
                    end
                tx_send:
                    // hold the request until the host has it
                    if (ack_sync) begin
                        out_req <= 1'b0;
                        state   <= tx_release;
                    end
                tx_release:
                    // phase four, host lets go of ack
                    if (!ack_sync) begin
                        state <= tx_idle;
                    end
                default:
                    state <= tx_idle;
            endcase
        end
    end

endmodule

//--- sim/ctrl_top_tb.sv
// testbench for the command controller top level
// plays host frames and expected replies from sim/frame_input.txt
// acks replies after random delays to vary the back-pressure
`include "ctrl_defs.svh"

module ctrl_top_tb;
    import ctrl_pkg::*;

    // wait limits in clocks
    localparam int hs_limit    = 16 * `CTRL_FLASH_BUSY + 64;
    localparam int reply_limit = 600;
    localparam int rec_words   = 512;

    logic          rx_flag;
    logic          transFinish;
    logic          in_req;
    logic [7:0]    in_data;
    logic          in_ack;
    logic          out_req;
    logic [7:0]    out_data;
    logic          out_ack;
    parser_state_e status;

    // records as kind, byte pairs
    logic [7:0]    rec_mem [rec_words];
    // reply bytes taken by the host model, oldest first
    logic [7:0]    got_q [$];
    logic [31:0]   lfsr_state = 32'hcd65_e99b;
    int            ack_delay;
    int            mismatch_count = 0;
    int            timeout_count = 0;
    int            other_count = 0;
    int            idx;
    int            rec_count;
    int            reply_num;
    bit            aborted;
    bit            ok;
    logic [7:0]    kind;
    logic [7:0]    val;
    logic [7:0]    got;

    ctrl_top i_ctrl_top (
        .rx_flag     (rx_flag),
        .transFinish (transFinish),
        .in_req      (in_req),
        .in_data     (in_data),
        .in_ack      (in_ack),
        .out_req     (out_req),
        .out_data    (out_data),
        .out_ack     (out_ack),
        .status      (status)
    );

    always #4 rx_flag = ~rx_flag;

    ////////////////////
    // helpers
    ////////////////////
    // galois lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s   = s >> 1;
        if (lsb) begin
            s = s ^ 32'h8020_0003;
        end
        return s;
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic check_reply(input logic [7:0] got_b, input logic [7:0] exp_b,
                               input string what);
        if (got_b !== exp_b) begin
            $display("MISMATCH at %0t: %s got %02h expected %02h", $time, what, got_b, exp_b);
            mismatch_count++;
        end
    endtask

    task automatic check_status(input parser_state_e got_s, input parser_state_e exp_s,
                                input string what);
        if (got_s !== exp_s) begin
            $display("MISMATCH at %0t: %s got %s expected %s", $time, what,
                     got_s.name(), exp_s.name());
            mismatch_count++;
        end
    endtask

    // host side of the byte input, all four phases
    task automatic send_byte(input logic [7:0] b, output bit done);
        int waited;
        done = 1'b1;
        @(negedge rx_flag);
        in_data = b;
        in_req  = 1'b1;
        waited  = 0;
        while (!in_ack && waited < hs_limit) begin
            @(negedge rx_flag);
            waited++;
        end
        if (!in_ack) begin
            $display("ERROR: in_ack never rose for host byte %02h at %0t", b, $time);
            done = 1'b0;
        end else begin
            in_req = 1'b0;
            waited = 0;
            while (in_ack && waited < hs_limit) begin
                @(negedge rx_flag);
                waited++;
            end
            if (in_ack) begin
                $display("ERROR: in_ack stayed high after host byte %02h at %0t", b, $time);
                done = 1'b0;
            end
        end
    endtask

    // next byte the host model has taken
    task automatic wait_reply(output logic [7:0] b, output bit done);
        int waited;
        waited = 0;
        b      = 8'h00;
        while (got_q.size() == 0 && waited < reply_limit) begin
            @(posedge rx_flag);
            waited++;
        end
        done = (got_q.size() != 0);
        if (done) begin
            b = got_q.pop_front();
        end
    endtask

    ////////////////////
    // host reply side
    ////////////////////
    // random ack delay per byte, polled on the falling edge
    always @(negedge rx_flag) begin
        if (!transFinish) begin
            if (out_req && !out_ack) begin
                if (ack_delay == 0) begin
                    got_q.push_back(out_data);
                    out_ack = 1'b1;
                end else begin
                    ack_delay = ack_delay - 1;
                end
            end else if (!out_req && out_ack) begin
                out_ack = 1'b0;
                draw_bits(4, ack_delay);
            end
        end
    end

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        rx_flag     = 1'b0;
        transFinish = 1'b1;
        in_req      = 1'b0;
        in_data     = 8'h00;
        out_ack     = 1'b0;
        aborted     = 1'b0;
        reply_num   = 0;
        $readmemh("sim/frame_input.txt", rec_mem);
        draw_bits(4, ack_delay);
        repeat (2) @(negedge rx_flag);
        transFinish = 1'b0;
        check_status(status, wait_head, "status after reset");

        idx       = 0;
        rec_count = 0;
        // kind 0 or an unread word ends the list
        while (!aborted && idx < rec_words - 1 && !$isunknown(rec_mem[idx])
               && rec_mem[idx] != 8'h00) begin
            kind = rec_mem[idx];
            val  = rec_mem[idx + 1];
            case (kind)
                8'h01: begin
                    send_byte(val, ok);
                    if (!ok) begin
                        timeout_count++;
                        aborted = 1'b1;
                    end
                end
                8'h02: begin
                    wait_reply(got, ok);
                    if (ok) begin
                        check_reply(got, val, $sformatf("reply byte %0d", reply_num));
                    end else begin
                        $display("ERROR: no reply byte arrived, expected %02h at %0t",
                                 val, $time);
                        timeout_count++;
                        aborted = 1'b1;
                    end
                    reply_num++;
                end
                8'h03: begin
                    // gaps sit between frames, parser back at head search
                    repeat (val) @(negedge rx_flag);
                    check_status(status, wait_head, "status between frames");
                end
                default: begin
                    $display("ERROR: unknown record kind %02h at word %0d", kind, idx);
                    other_count++;
                    aborted = 1'b1;
                end
            endcase
            idx += 2;
            rec_count++;
        end
        if (rec_count == 0) begin
            $display("ERROR: no records were read from the input file");
            other_count++;
        end

        // anything arriving now was never asked for
        repeat (64) @(negedge rx_flag);
        if (!aborted && got_q.size() != 0) begin
            $display("ERROR: %0d reply bytes arrived that no record expects", got_q.size());
            other_count++;
        end

        $display("errors: %0d mismatch, %0d timeout, %0d other",
                 mismatch_count, timeout_count, other_count);
        if (mismatch_count + timeout_count + other_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- sim/frame_input.txt
// kind then byte: 1 host byte, 2 expected reply byte, 3 idle gap in clocks
// kind 0 ends the list
// junk ahead of a frame is dropped
01 12
01 34
03 10
// ram write of 3 bytes at 05
01 aa
01 03
01 02
01 05
01 de
01 ad
01 be
02 55
03 04
// unknown opcode is refused
01 aa
01 01
01 77
02 ee
03 04
// empty flash write acks
01 aa
01 00
01 04
01 00
02 55
03 04
// empty ram read stays silent
01 aa
01 00
01 01
01 00
03 20
// ram read back at 05
01 aa
01 03
01 01
01 05
02 de
02 ad
02 be
03 04
// flash reads erased after reset
01 aa
01 01
01 08
01 07
02 ff
03 04
// program f0 5a at 07, then 3c at 07
01 aa
01 02
01 04
01 07
01 f0
01 5a
02 55
03 04
01 aa
01 01
01 04
01 07
01 3c
02 55
03 04
// f0 and 3c give 30
01 aa
01 02
01 08
01 07
02 30
02 5a
03 04
00 00

//--- tb.f
+incdir+logic
logic/ctrl_pkg.sv
logic/byte_rx_sync.sv
logic/frame_parser.sv
logic/ram_engine.sv
logic/flash_engine.sv
logic/resp_tx.sv
logic/ctrl_top.sv
sim/ctrl_top_tb.sv
